/* Makefile */
# Verilator build and run of the NES host testbench

VERILATOR ?= verilator
TOP       ?= nes_host_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/nes_host_asserts.sv */
// NES host assertions
// Loader FSM and console reset properties, bound into the loader and reset control
`timescale 1ns/1ps
`default_nettype none

module nes_host_asserts (
	input wire                              clk,
	input wire                              reset_nes,
	input wire nes_host_pkg::loader_state_e state,
	input wire                              mem_write,
	input wire                              busy,
	input wire                              done,
	input wire                              loader_error,
	input wire                              cpu_reset
);

	int fail_count = 0;   // Tally of failed properties

	// Payload writes only while a region is being filled
	write_in_payload: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> (state == nes_host_pkg::LOAD_PRG || state == nes_host_pkg::LOAD_CHR))
	else begin
		fail_count++;
		$error("mem_write outside the PRG and CHR states");
	end

	done_busy_exclusive: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy))
	else begin
		fail_count++;
		$error("Loader done and busy high together");
	end

	// Bad file keeps the console held
	error_holds_reset: assert property (@(posedge clk) disable iff (reset_nes)
		loader_error |-> cpu_reset)
	else begin
		fail_count++;
		$error("cpu_reset low while loader_error is high");
	end

endmodule

`default_nettype wire

/* dv/nes_host_tb.sv */
// NES host testbench
// Table-driven loads of iNES files, a cheat file and controller reads
`timescale 1ns/1ps
`default_nettype none

module nes_host_tb;

	localparam int CLK_PERIOD = 20;
	localparam int WAIT_LIMIT = 1000;
	localparam int SETTLE_MARGIN = 8;
	localparam logic [31:0] SEED = 32'h994f_3ca2;

	typedef struct packed {
		logic [7:0] prg;
		logic [7:0] chr;
		logic [7:0] b6;
		logic [7:0] b7;
		logic [7:0] b8;
		logic [7:0] b12;   // Inside the dirty-header range
		logic       inv;
		logic       bad_magic;
		logic       early;   // Active drops inside PRG
	} file_case_t;

	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		logic       swap;
		logic       tap;
	} pad_case_t;

	file_case_t files [7] = '{
		'{8'd2, 8'd1, 8'h10, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0},
		'{8'd1, 8'd0, 8'h43, 8'h20, 8'hC3, 8'h55, 1'b0, 1'b0, 1'b0},   // Dirty, CHR RAM
		'{8'd1, 8'd1, 8'h09, 8'h38, 8'h5A, 8'h77, 1'b1, 1'b0, 1'b0},   // iNES 2.0
		'{8'd3, 8'd2, 8'h21, 8'hA0, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0},
		'{8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0},
		'{8'd1, 8'd1, 8'h04, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0},   // Trainer
		'{8'd1, 8'd1, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1}
	};

	pad_case_t pads [4] = '{
		'{8'h81, 8'h3C, 8'h5A, 8'hC3, 1'b0, 1'b0},
		'{8'h81, 8'h3C, 8'h5A, 8'hC3, 1'b1, 1'b0},
		'{8'h12, 8'hE4, 8'h0F, 8'hF0, 1'b0, 1'b1},
		'{8'h12, 8'hE4, 8'h0F, 8'hF0, 1'b1, 1'b1}
	};

	logic clk;
	logic reset_nes;
	logic dl_active;
	logic dl_wr;
	logic [nes_host_pkg::DL_ADDR_W-1:0] dl_addr;
	logic [7:0] dl_data;
	logic [7:0] dl_index;
	logic invert_mirroring;
	logic [7:0] pad_a;
	logic [7:0] pad_b;
	logic [7:0] pad_c;
	logic [7:0] pad_d;
	logic joy_swap;
	logic multitap;
	logic joy_strobe;
	logic [1:0] joy_clock;

	logic [nes_host_pkg::MEM_ADDR_W-1:0] mem_addr;
	logic [7:0] mem_data;
	logic mem_write;
	nes_host_pkg::mapper_flags_t mapper_flags;
	logic loader_busy;
	logic loader_done;
	logic loader_error;
	logic [nes_host_pkg::CHEAT_W-1:0] cheat_code;
	logic code_valid;
	logic [1:0] joy_data;
	logic cpu_reset;

	// Outputs seen while a byte strobe is high
	logic seen_write;
	logic [nes_host_pkg::MEM_ADDR_W-1:0] seen_addr;
	logic [7:0] seen_data;
	logic seen_reset;
	int write_count = 0;
	int valid_count = 0;

	nes_host_top nes_host_top_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl_active        (dl_active),
		.dl_wr            (dl_wr),
		.dl_addr          (dl_addr),
		.dl_data          (dl_data),
		.dl_index         (dl_index),
		.invert_mirroring (invert_mirroring),
		.pad_a            (pad_a),
		.pad_b            (pad_b),
		.pad_c            (pad_c),
		.pad_d            (pad_d),
		.joy_swap         (joy_swap),
		.multitap         (multitap),
		.joy_strobe       (joy_strobe),
		.joy_clock        (joy_clock),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.loader_busy      (loader_busy),
		.loader_done      (loader_done),
		.loader_error     (loader_error),
		.cheat_code       (cheat_code),
		.code_valid       (code_valid),
		.joy_data         (joy_data),
		.cpu_reset        (cpu_reset)
	);

	bind ines_loader nes_host_asserts loader_checks (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.state        (state),
		.mem_write    (mem_write),
		.busy         (busy),
		.done         (done),
		.loader_error (error),
		.cpu_reset    (1'b1)   // Console reset lives in reset control
	);

	bind console_reset_ctrl nes_host_asserts reset_checks (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.state        (nes_host_pkg::LOAD_HEADER),
		.mem_write    (1'b0),
		.busy         (loader_busy),
		.done         (1'b0),
		.loader_error (loader_error),
		.cpu_reset    (cpu_reset)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (mem_write)
			write_count++;
		if (code_valid)
			valid_count++;
	end

	//////////////////////////////
	// Checks and reference model
	//////////////////////////////

	task automatic compare_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		$display("Checks failed");
		$fatal(1, "Wait limit reached");
	endtask

	// Smallest c with 2**c >= pages, at most 7
	function automatic logic [2:0] size_for(input logic [7:0] pages);
		int c;
		c = 0;
		while (c < 7 && (1 << c) < int'(pages))
			c++;
		return 3'(c);
	endfunction

	function automatic nes_host_pkg::mapper_flags_t expected_flags(input file_case_t fc);
		nes_host_pkg::mapper_flags_t f;
		logic ines2;
		logic dirty;
		ines2 = fc.b7[3:2] == 2'b10;
		dirty = !ines2 && fc.b12 != 8'h00;
		f = '0;
		f.has_saves = fc.b6[1];
		f.submapper_byte = ines2 ? fc.b8 : 8'h00;
		f.four_screen = fc.b6[3];
		f.chr_ram = fc.chr == 8'd0;
		f.mirroring = fc.b6[0] ^ fc.inv;
		f.chr_size = size_for(fc.chr);
		f.prg_size = size_for(fc.prg);
		f.mapper = {dirty ? 4'h0 : fc.b7[7:4], fc.b6[7:4]};
		return f;
	endfunction

	// Report bit k from host bit src[k]: A B Select Start Up Down Left Right
	function automatic logic [7:0] report_order(input logic [7:0] host);
		int src [8];
		logic [7:0] r;
		src = '{4, 5, 6, 7, 3, 2, 1, 0};
		for (int k = 0; k < 8; k++)
			r[k] = host[src[k]];
		return r;
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic send_byte(input logic [nes_host_pkg::DL_ADDR_W-1:0] addr,
		input logic [7:0] data);
		@(posedge clk);
		dl_wr <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(negedge clk);
		seen_write = mem_write;
		seen_addr = mem_addr;
		seen_data = mem_data;
		seen_reset = cpu_reset;
		@(posedge clk);
		dl_wr <= 1'b0;
	endtask

	task automatic load_file(input file_case_t fc);
		logic [7:0] hdr [16];
		logic [7:0] b;
		logic [nes_host_pkg::MEM_ADDR_W-1:0] exp_addr;
		logic good;
		int prg_bytes;
		int n_send;
		int start_writes;
		int cycles;
		for (int i = 0; i < 16; i++)
			hdr[i] = 8'h00;
		hdr[0] = 8'h4E;
		hdr[1] = fc.bad_magic ? 8'h46 : 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = fc.prg;
		hdr[5] = fc.chr;
		hdr[6] = fc.b6;
		hdr[7] = fc.b7;
		hdr[8] = fc.b8;
		hdr[12] = fc.b12;
		good = !fc.bad_magic && !fc.b6[2];
		prg_bytes = int'(fc.prg) << nes_host_pkg::PRG_PAGE_SHIFT;
		if (!good)
			n_send = 8;
		else if (fc.early)
			n_send = 100;
		else
			n_send = prg_bytes + (int'(fc.chr) << nes_host_pkg::CHR_PAGE_SHIFT);

		@(posedge clk);
		start_writes = write_count;
		dl_index <= 8'h01;
		invert_mirroring <= fc.inv;
		dl_active <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			send_byte(25'(i), hdr[i]);
			compare_value(128'(seen_write), 128'(1'b0), "write on a header byte");
			compare_value(128'(seen_reset), 128'(1'b1), "cpu_reset during header");
		end
		for (int i = 0; i < n_send; i++) begin
			b = 8'($urandom);
			exp_addr = (i < prg_bytes) ? nes_host_pkg::PRG_BASE + 22'(i)
				: nes_host_pkg::CHR_BASE + 22'(i - prg_bytes);
			send_byte(25'(16 + i), b);
			compare_value(128'(seen_write), 128'(good), "payload write strobe");
			compare_value(128'(seen_reset), 128'(1'b1), "cpu_reset during payload");
			if (good) begin
				compare_value(128'(seen_addr), 128'(exp_addr), "payload address");
				compare_value(128'(seen_data), 128'(b), "payload data");
			end
		end
		if (good && !fc.early) begin
			for (int i = 0; i < 2; i++) begin   // Trailing bytes
				send_byte(25'(16 + n_send + i), 8'hA5);
				compare_value(128'(seen_write), 128'(1'b0), "write after the last byte");
			end
		end
		@(posedge clk);
		dl_active <= 1'b0;

		cycles = 0;
		@(negedge clk);
		while (!loader_done) begin
			if (cycles == WAIT_LIMIT)
				report_timeout("loader done");
			cycles++;
			@(negedge clk);
		end
		compare_value(128'(loader_busy), 128'(1'b0), "loader busy at end");
		compare_value(128'(loader_error), 128'(!good || fc.early), "loader error");
		@(posedge clk);
		compare_value(128'(write_count - start_writes), 128'(good ? n_send : 0),
			"number of memory writes");

		if (!good || fc.early) begin
			repeat (nes_host_pkg::SETTLE_CYCLES + SETTLE_MARGIN) begin
				@(negedge clk);
				compare_value(128'(cpu_reset), 128'(1'b1), "cpu_reset after a bad file");
			end
		end else begin
			compare_value(128'(mapper_flags), 128'(expected_flags(fc)), "mapper flags");
			cycles = 0;
			@(negedge clk);
			while (cpu_reset) begin
				if (cycles == nes_host_pkg::SETTLE_CYCLES + SETTLE_MARGIN)
					report_timeout("console reset release");
				cycles++;
				@(negedge clk);
			end
		end
	endtask

	task automatic load_cheat();
		logic [127:0] exp_code;
		logic [7:0] b;
		nes_host_pkg::mapper_flags_t flags_before;
		logic [3:0] status_before;
		int valid_before;
		int pos;
		exp_code = '0;
		@(posedge clk);
		flags_before = mapper_flags;
		status_before = {loader_busy, loader_done, loader_error, cpu_reset};
		valid_before = valid_count;
		dl_index <= nes_host_pkg::FILETYPE_CHEAT;
		dl_active <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			b = 8'($urandom);
			pos = (3 - i / 4) * 32 + (i % 4) * 8;   // Flags on top, replace at the bottom
			exp_code[pos +: 8] = b;
			send_byte(25'(i), b);
			compare_value(128'(seen_write), 128'(1'b0), "write during cheat file");
			compare_value(128'(seen_reset), 128'(status_before[0]), "cpu_reset in cheat load");
		end
		@(posedge clk);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk);
		compare_value(128'(valid_count - valid_before), 128'(1), "code_valid pulses");
		compare_value(cheat_code, exp_code, "cheat code");
		compare_value(128'(mapper_flags), 128'(flags_before), "flags after cheat file");
		compare_value(128'({loader_busy, loader_done, loader_error, cpu_reset}),
			128'(status_before), "loader status after cheat file");
	endtask

	task automatic read_pads(input pad_case_t pc);
		logic [23:0] exp0;
		logic [23:0] exp1;
		exp0 = {pc.tap ? {8'h08, report_order(pc.c)} : 16'hFFFF,
			report_order(pc.swap ? pc.b : pc.a)};
		exp1 = {pc.tap ? {8'h04, report_order(pc.d)} : 16'hFFFF,
			report_order(pc.swap ? pc.a : pc.b)};
		@(posedge clk);
		pad_a <= pc.a;
		pad_b <= pc.b;
		pad_c <= pc.c;
		pad_d <= pc.d;
		joy_swap <= pc.swap;
		multitap <= pc.tap;
		joy_strobe <= 1'b1;
		@(posedge clk);
		joy_strobe <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 24; i++) begin
			compare_value(128'(joy_data), 128'({exp1[i], exp0[i]}), "joypad serial bit");
			@(posedge clk);
			joy_clock <= 2'b11;
			@(posedge clk);
			joy_clock <= 2'b00;
			@(posedge clk);   // Shift lands one cycle after the fall
			@(negedge clk);
		end
		compare_value(128'(joy_data), 128'(2'b00), "joypad data after 24 bits");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(SEED));
		reset_nes = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = 8'h00;
		dl_index = 8'h00;
		invert_mirroring = 1'b0;
		pad_a = 8'h00;
		pad_b = 8'h00;
		pad_c = 8'h00;
		pad_d = 8'h00;
		joy_swap = 1'b0;
		multitap = 1'b0;
		joy_strobe = 1'b0;
		joy_clock = 2'b00;
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;

		@(negedge clk);
		compare_value(128'({mem_write, loader_busy, loader_done, loader_error, code_valid}),
			128'(5'b00000), "outputs after reset");
		compare_value(128'(joy_data), 128'(2'b00), "joy_data after reset");
		compare_value(128'(cpu_reset), 128'(1'b1), "cpu_reset before first load");

		for (int i = 0; i < 7; i++) begin
			load_file(files[i]);
			if (i == 0)
				load_cheat();
		end
		// Cartridge files never complete a cheat record
		compare_value(128'(valid_count), 128'(1), "code_valid pulses over all files");
		for (int i = 0; i < 4; i++)
			read_pads(pads[i]);

		repeat (2) @(posedge clk);
		if (nes_host_top_inst.ines_loader_inst.loader_checks.fail_count
			+ nes_host_top_inst.console_reset_ctrl_inst.reset_checks.fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Assertion failures were recorded during the run");
			$display("Checks failed");
			$fatal(1, "Assertion failures");
		end
	end

endmodule

`default_nettype wire

/* source/cheat_code_collector.sv */
// Cheat code collector
// Builds 128-bit codes from 16-byte cheat records and pulses each one out
`timescale 1ns/1ps
`default_nettype none

module cheat_code_collector (
	input  wire                                  clk,
	input  wire                                  reset_nes,
	host_download_if.sink                        dl,
	output logic [nes_host_pkg::CHEAT_W-1:0]     cheat_code,
	output logic                                 code_valid
);

	logic cheat_wr;
	nes_host_pkg::cheat_field_e field;
	logic [6:0] field_base;
	logic [6:0] byte_pos;

	assign cheat_wr = dl.wr && dl.active && nes_host_pkg::is_cheat_file(dl.index);
	assign field = nes_host_pkg::cheat_field_e'(dl.addr[3:2]);

	// Layout from the top: flags, address, compare, replace
	always_comb begin
		case (field)
			nes_host_pkg::CHEAT_FLAGS:   field_base = 7'd96;
			nes_host_pkg::CHEAT_ADDRESS: field_base = 7'd64;
			nes_host_pkg::CHEAT_COMPARE: field_base = 7'd32;
			nes_host_pkg::CHEAT_REPLACE: field_base = 7'd0;
		endcase
	end

	assign byte_pos = field_base + 7'({dl.addr[1:0], 3'b000});   // Byte 0 is the LSB

	always_ff @(posedge clk) begin
		if (cheat_wr)
			cheat_code[byte_pos +: 8] <= dl.data;
	end

	// Last byte of a record completes the code
	always_ff @(posedge clk) begin
		if (reset_nes)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_wr && dl.addr[3:0] == 4'hF;
	end

endmodule

`default_nettype wire

/* source/console_reset_ctrl.sv */
// Console reset control
// Holds the console in reset before the first load, during a load,
// through the settle time after it and after a bad file
`timescale 1ns/1ps
`default_nettype none

module console_reset_ctrl (
	input  wire           clk,
	input  wire           reset_nes,
	host_download_if.sink dl,
	input  wire           loader_busy,
	input  wire           loader_error,
	output logic          cpu_reset
);

	logic loading;
	logic load_seen;   // Any cartridge load started
	logic [$clog2(nes_host_pkg::SETTLE_CYCLES + 1)-1:0] settle_cnt;

	assign loading = dl.active && !nes_host_pkg::is_cheat_file(dl.index);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			load_seen <= 1'b0;
			settle_cnt <= '0;
		end else begin
			if (loading)
				load_seen <= 1'b1;
			if (loading)
				settle_cnt <= $bits(settle_cnt)'(nes_host_pkg::SETTLE_CYCLES);
			else if (!loader_busy && settle_cnt != '0)
				settle_cnt <= settle_cnt - 1'b1;   // Count down once loader is idle
		end
	end

	assign cpu_reset = reset_nes || !load_seen || loading
		|| settle_cnt != '0 || loader_error;

endmodule

`default_nettype wire

/* source/host_download_if.sv */
// Host download bundle
// File byte stream from the host to the loader, cheat collector and reset control
`timescale 1ns/1ps
`default_nettype none

interface host_download_if;

	logic                                active;   // High for the whole file
	logic                                wr;       // One strobe per byte
	logic [nes_host_pkg::DL_ADDR_W-1:0]  addr;
	logic [7:0]                          data;
	logic [7:0]                          index;    // File type

	modport host (
		output active,
		output wr,
		output addr,
		output data,
		output index
	);

	modport sink (
		input active,
		input wr,
		input addr,
		input data,
		input index
	);

endinterface

`default_nettype wire

/* source/ines_loader.sv */
// iNES cartridge loader
// Parses the 16-byte header, writes PRG and CHR payload to memory
// and freezes the mapper flags at the end of the file
`timescale 1ns/1ps
`default_nettype none

module ines_loader (
	input  wire                                    clk,
	input  wire                                    reset_nes,
	host_download_if.sink                          dl,
	input  wire                                    invert_mirroring,
	output logic [nes_host_pkg::MEM_ADDR_W-1:0]    mem_addr,
	output logic [7:0]                             mem_data,
	output logic                                   mem_write,
	output nes_host_pkg::mapper_flags_t            mapper_flags,
	output logic                                   busy,
	output logic                                   done,
	output logic                                   error
);

	nes_host_pkg::loader_state_e state;

	logic active_q;
	logic byte_wr;
	logic load_start;
	logic hdr_we;
	logic [$clog2(nes_host_pkg::HEADER_BYTES):0] hdr_cnt;   // Counts to 16
	logic [$clog2(nes_host_pkg::HEADER_BYTES)-1:0] hdr_idx;
	logic [7:0] header [nes_host_pkg::HEADER_BYTES];
	logic [nes_host_pkg::MEM_ADDR_W-1:0] remaining;   // Payload bytes left in region

	logic header_full, header_ok;
	logic hdr_accept, hdr_reject;
	logic prg_end, chr_end;
	logic is_nes20, is_dirty;
	nes_host_pkg::mapper_flags_t flags_live;

	// Size code of a page count, ceil(log2(n)) capped at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (8'd1 << i))
				code = 3'(i + 1);
		end
		return code;
	endfunction

	//////////////////////////////
	// Byte strobes
	//////////////////////////////

	assign byte_wr = dl.wr && dl.active && !nes_host_pkg::is_cheat_file(dl.index);
	assign load_start = dl.active && !active_q && !nes_host_pkg::is_cheat_file(dl.index);

	// A byte may arrive in the same cycle as the start edge
	assign hdr_we = byte_wr && (load_start || (state == nes_host_pkg::LOAD_HEADER
		&& hdr_cnt < nes_host_pkg::HEADER_BYTES));
	assign hdr_idx = load_start ? '0 : hdr_cnt[$bits(hdr_idx)-1:0];

	// Busy spans the PRG and CHR regions
	assign mem_write = byte_wr && !load_start && busy && remaining != '0;
	assign mem_data = dl.data;

	//////////////////////////////
	// Header checks and flags
	//////////////////////////////

	assign header_full = state == nes_host_pkg::LOAD_HEADER && !load_start
		&& hdr_cnt == nes_host_pkg::HEADER_BYTES;
	assign header_ok = header[0] == 8'h4E && header[1] == 8'h45 && header[2] == 8'h53
		&& header[3] == 8'h1A && !header[6][2];   // "NES" 1A, no trainer
	assign hdr_accept = header_full && header_ok;
	assign hdr_reject = header_full && !header_ok;

	assign prg_end = state == nes_host_pkg::LOAD_PRG && remaining == '0;
	assign chr_end = state == nes_host_pkg::LOAD_CHR && remaining == '0;

	assign is_nes20 = header[7][3:2] == 2'b10;
	assign is_dirty = !is_nes20 && (|{header[10], header[11], header[12],
		header[13], header[14], header[15]});

	always_comb begin
		flags_live = '0;
		flags_live.has_saves = header[6][1];
		flags_live.submapper_byte = is_nes20 ? header[8] : 8'h00;
		flags_live.four_screen = header[6][3];
		flags_live.chr_ram = header[5] == 8'h00;
		flags_live.mirroring = header[6][0] ^ invert_mirroring;
		flags_live.chr_size = size_code(header[5]);
		flags_live.prg_size = size_code(header[4]);
		flags_live.mapper = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			active_q <= 1'b0;
			state <= nes_host_pkg::LOAD_HEADER;
			hdr_cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			active_q <= dl.active;
			if (load_start) begin
				state <= nes_host_pkg::LOAD_HEADER;
				hdr_cnt <= $bits(hdr_cnt)'(byte_wr);
				busy <= 1'b0;
				done <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
					nes_host_pkg::LOAD_HEADER: begin
						if (hdr_we)
							hdr_cnt <= hdr_cnt + 1'b1;
						else if (hdr_accept) begin
							busy <= 1'b1;
							state <= nes_host_pkg::LOAD_PRG;
						end else if (hdr_reject) begin
							state <= nes_host_pkg::LOAD_ERROR;
							done <= 1'b1;
							error <= 1'b1;
						end
					end
					nes_host_pkg::LOAD_PRG, nes_host_pkg::LOAD_CHR: begin
						if (prg_end)
							state <= nes_host_pkg::LOAD_CHR;
						else if (chr_end) begin
							state <= nes_host_pkg::LOAD_DONE;
							busy <= 1'b0;
							done <= 1'b1;
						end else if (!dl.active) begin   // File ended short
							state <= nes_host_pkg::LOAD_ERROR;
							busy <= 1'b0;
							done <= 1'b1;
							error <= 1'b1;
						end
					end
					nes_host_pkg::LOAD_DONE, nes_host_pkg::LOAD_ERROR: begin
						// Wait here for the next file
					end
					default: state <= nes_host_pkg::LOAD_HEADER;
				endcase
			end
		end
	end

	// Header store, region address and byte count
	always_ff @(posedge clk) begin
		if (hdr_we)
			header[hdr_idx] <= dl.data;
		if (hdr_accept) begin
			mem_addr <= nes_host_pkg::PRG_BASE;
			remaining <= nes_host_pkg::MEM_ADDR_W'(header[4]) << nes_host_pkg::PRG_PAGE_SHIFT;
		end else if (prg_end) begin
			mem_addr <= nes_host_pkg::CHR_BASE;
			remaining <= nes_host_pkg::MEM_ADDR_W'(header[5]) << nes_host_pkg::CHR_PAGE_SHIFT;
		end else if (mem_write) begin
			mem_addr <= mem_addr + 1'b1;
			remaining <= remaining - 1'b1;
		end
		if (chr_end)
			mapper_flags <= flags_live;   // Frozen at load end
	end

endmodule

`default_nettype wire

/* source/joypad_serializer.sv */
// Joypad serializer
// Latches two NES controller reports on strobe, with optional multitap,
// and shifts each port out on its own clock
`timescale 1ns/1ps
`default_nettype none

module joypad_serializer (
	input  wire        clk,
	input  wire        reset_nes,
	input  wire [7:0]  pad_a,
	input  wire [7:0]  pad_b,
	input  wire [7:0]  pad_c,
	input  wire [7:0]  pad_d,
	input  wire        joy_swap,
	input  wire        multitap,
	input  wire        strobe,
	input  wire [1:0]  port_clock,
	output logic [1:0] joy_data
);

	logic [7:0] nes_a, nes_b, nes_c, nes_d;
	logic [23:0] report [2];
	logic [23:0] shreg [2];
	logic [1:0] clock_q;
	logic [1:0] clock_fall;

	// Host order to NES order, A ends up in bit 0
	function automatic logic [7:0] nes_order(input logic [7:0] host);
		return {host[0], host[1], host[2], host[3], host[7], host[6], host[5], host[4]};
	endfunction

	assign nes_a = nes_order(pad_a);
	assign nes_b = nes_order(pad_b);
	assign nes_c = nes_order(pad_c);
	assign nes_d = nes_order(pad_d);

	//////////////////////////////
	// Reports
	//////////////////////////////

	// Multitap adds pads C and D and a port signature
	assign report[0] = {multitap ? {8'h08, nes_c} : 16'hFFFF, joy_swap ? nes_b : nes_a};
	assign report[1] = {multitap ? {8'h04, nes_d} : 16'hFFFF, joy_swap ? nes_a : nes_b};

	assign clock_fall = clock_q & ~port_clock;

	//////////////////////////////
	// Shift registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			clock_q <= '0;
			for (int n = 0; n < 2; n++) begin
				shreg[n] <= '0;
			end
		end else begin
			clock_q <= port_clock;
			for (int n = 0; n < 2; n++) begin
				if (strobe)
					shreg[n] <= report[n];   // Reload while strobe is high
				else if (clock_fall[n])
					shreg[n] <= {1'b0, shreg[n][23:1]};
			end
		end
	end

	assign joy_data = {shreg[1][0], shreg[0][0]};

endmodule

`default_nettype wire

/* source/nes_host_pkg.sv */
// NES host package
// Shared widths, memory map, file types and the loader types
`default_nettype none

package nes_host_pkg;

	//////////////////////////////
	// Widths and memory map
	//////////////////////////////

	localparam int MEM_ADDR_W = 22;   // Cartridge memory address
	localparam int DL_ADDR_W  = 25;   // Download byte offset
	localparam int HEADER_BYTES = 16;
	localparam int PRG_PAGE_SHIFT = 14;   // 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;   // 8 KiB pages

	localparam logic [MEM_ADDR_W-1:0] PRG_BASE = '0;
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h20_0000;

	localparam logic [7:0] FILETYPE_CHEAT = 8'hFF;
	localparam int SETTLE_CYCLES = 255;   // Reset hold after a load
	localparam int CHEAT_W = 128;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} loader_state_e;

	// Cheat record field, picked by offset bits 3..2
	typedef enum logic [1:0] {
		CHEAT_FLAGS,
		CHEAT_ADDRESS,
		CHEAT_COMPARE,
		CHEAT_REPLACE
	} cheat_field_e;

	typedef struct packed {
		logic [5:0] reserved;
		logic       has_saves;
		logic [7:0] submapper_byte;   // Byte 8 on iNES 2.0 only
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	function automatic logic is_cheat_file(input logic [7:0] index);
		return index == FILETYPE_CHEAT;
	endfunction

endpackage

`default_nettype wire

/* source/nes_host_top.sv */
// NES host top level
// Download lines, cartridge loader, cheat collector, joypads and console reset
`timescale 1ns/1ps
`default_nettype none

module nes_host_top (
	input  wire                                   clk,
	input  wire                                   reset_nes,
	input  wire                                   dl_active,
	input  wire                                   dl_wr,
	input  wire [nes_host_pkg::DL_ADDR_W-1:0]     dl_addr,
	input  wire [7:0]                             dl_data,
	input  wire [7:0]                             dl_index,
	input  wire                                   invert_mirroring,
	input  wire [7:0]                             pad_a,
	input  wire [7:0]                             pad_b,
	input  wire [7:0]                             pad_c,
	input  wire [7:0]                             pad_d,
	input  wire                                   joy_swap,
	input  wire                                   multitap,
	input  wire                                   joy_strobe,
	input  wire [1:0]                             joy_clock,
	output logic [nes_host_pkg::MEM_ADDR_W-1:0]   mem_addr,
	output logic [7:0]                            mem_data,
	output logic                                  mem_write,
	output nes_host_pkg::mapper_flags_t           mapper_flags,
	output logic                                  loader_busy,
	output logic                                  loader_done,
	output logic                                  loader_error,
	output logic [nes_host_pkg::CHEAT_W-1:0]      cheat_code,
	output logic                                  code_valid,
	output logic [1:0]                            joy_data,
	output logic                                  cpu_reset
);

	host_download_if dl_if ();

	// Host side of the download bundle
	assign dl_if.active = dl_active;
	assign dl_if.wr     = dl_wr;
	assign dl_if.addr   = dl_addr;
	assign dl_if.data   = dl_data;
	assign dl_if.index  = dl_index;

	ines_loader ines_loader_inst (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.dl               (dl_if),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error)
	);

	cheat_code_collector cheat_code_collector_inst (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.dl         (dl_if),
		.cheat_code (cheat_code),
		.code_valid (code_valid)
	);

	joypad_serializer joypad_serializer_inst (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.pad_a      (pad_a),
		.pad_b      (pad_b),
		.pad_c      (pad_c),
		.pad_d      (pad_d),
		.joy_swap   (joy_swap),
		.multitap   (multitap),
		.strobe     (joy_strobe),
		.port_clock (joy_clock),
		.joy_data   (joy_data)
	);

	console_reset_ctrl console_reset_ctrl_inst (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.dl           (dl_if),
		.loader_busy  (loader_busy),
		.loader_error (loader_error),
		.cpu_reset    (cpu_reset)
	);

endmodule

`default_nettype wire

/* src.f */
source/nes_host_pkg.sv
source/host_download_if.sv
source/ines_loader.sv
source/cheat_code_collector.sv
source/joypad_serializer.sv
source/console_reset_ctrl.sv
source/nes_host_top.sv
dv/nes_host_asserts.sv
dv/nes_host_tb.sv
